//--- verif/capture_input.txt
# Column 1: raw 16-bit sample code sent over the four lanes (hex)
# Column 2: expected 32-bit host word, the code sign-extended (hex)
1234 00001234
8000 ffff8000
7fff 00007fff
fedc fffffedc
0001 00000001
a5c3 ffffa5c3
0000 00000000
ffff ffffffff
4c1d 00004c1d
9e07 ffff9e07
3b62 00003b62
c0de ffffc0de
5a5a 00005a5a
8001 ffff8001
0f0f 00000f0f
e4b3 ffffe4b3
6d29 00006d29
b710 ffffb710

//--- build.f
verilog/adc_cfg_pkg.sv
verilog/capture_pkg.sv
verilog/conv_sequencer.sv
verilog/echo_capture.sv
verilog/sample_fifo.sv
verilog/sample_reader.sv
verilog/adc_capture_top.sv
verif/adc_capture_assertions.sv
verif/adc_capture_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module adc_capture_tb -f build.f -o adc_capture_sim

./obj_dir/adc_capture_sim | tee sim.log

grep -qx "test passed" sim.log

//--- verif/adc_capture_tb.sv
`timescale 1ns/1ns

module adc_capture_tb
  import adc_cfg_pkg::*;
  import capture_pkg::*;
();

  localparam int FIFO_DEPTH  = 16;
  localparam int IRQ_LEVEL   = 4;
  localparam int ECHO_DELAY  = 18;
  localparam int BUSY_CYCLES = 20;
  localparam int CS_TIMEOUT  = 200;
  // Overflow test pushes two more samples than the FIFO holds
  localparam int OVF_CONV    = FIFO_DEPTH + 2;
  localparam int FIRST_CONV  = 6;

  logic               delay_clk = 1'b0;
  logic               arst_n;
  logic               start;
  logic               rd;
  logic               busy      = 1'b0;
  logic               echo_sclk = 1'b0;
  logic [NUM_SDI-1:0] sdi       = '0;
  logic               cnv;
  logic               spi_cs;
  logic               spi_sclk;
  host_word_t         sample_word;
  logic               sample_valid;
  logic               irq;
  logic               overflow;

  // Stimulus and expected words from the data file
  raw_sample_t raw_codes[$];
  host_word_t  exp_words[$];
  logic        loaded = 1'b0;
  int          value_errors = 0;
  int          proto_errors = 0;
  logic [31:0] lfsr_state = 32'h8e62;

  always #4 delay_clk = ~delay_clk;

  adc_capture_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .IRQ_LEVEL  (IRQ_LEVEL)
  ) u_adc_capture_top (
    .delay_clk    (delay_clk),
    .arst_n       (arst_n),
    .start        (start),
    .busy         (busy),
    .echo_sclk    (echo_sclk),
    .sdi          (sdi),
    .rd           (rd),
    .cnv          (cnv),
    .spi_cs       (spi_cs),
    .spi_sclk     (spi_sclk),
    .sample_word  (sample_word),
    .sample_valid (sample_valid),
    .irq          (irq),
    .overflow     (overflow)
  );

  // ******************************************************************
  // Converter model and board delay line
  // ******************************************************************

  logic [ECHO_DELAY-1:0] echo_line = '0;
  raw_sample_t           cur_code  = '0;
  int                    busy_left = 0;
  int                    bit_idx   = 0;
  logic                  cnv_prev  = 1'b0;
  logic                  cs_prev   = 1'b1;
  logic                  echo_prev = 1'b0;

  // Lane k sends bits k*BITS_PER_LANE upward, highest first
  function automatic logic [NUM_SDI-1:0] lane_bits(input raw_sample_t code, input int b);
    logic [NUM_SDI-1:0] v;
    for (int k = 0; k < NUM_SDI; k++) begin
      v[k] = code[k * BITS_PER_LANE + b];
    end
    return v;
  endfunction

  always @(posedge delay_clk) begin
    #1;
    // Busy rises as the convert pulse ends and holds for the conversion time
    if (cnv_prev && !cnv) begin
      busy      = 1'b1;
      busy_left = BUSY_CYCLES;
    end else if (busy_left > 0) begin
      busy_left--;
      if (busy_left == 0) begin
        busy = 1'b0;
      end
    end
    cnv_prev = cnv;
    // Serial clock comes back late by the length of the delay line
    echo_line = {echo_line[ECHO_DELAY-2:0], spi_sclk};
    echo_sclk = echo_line[ECHO_DELAY-1];
    // First bit appears with chip select, the rest on falling echo edges
    if (cs_prev && !spi_cs) begin
      bit_idx = BITS_PER_LANE - 1;
      sdi     = lane_bits(cur_code, bit_idx);
    end else if (echo_prev && !echo_sclk && bit_idx > 0) begin
      bit_idx--;
      sdi = lane_bits(cur_code, bit_idx);
    end
    cs_prev   = spi_cs;
    echo_prev = echo_sclk;
  end

  // ******************************************************************
  // Helpers
  // ******************************************************************

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic random_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic idle_gap(input int bits);
    int n;
    random_bits(bits, n);
    repeat (n) begin
      @(posedge delay_clk);
      #1;
    end
  endtask

  task automatic check_word(input string name, input host_word_t got, input host_word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic load_file();
    int          fd;
    string       line;
    raw_sample_t code;
    host_word_t  word;
    fd = $fopen("verif/capture_input.txt", "r");
    if (fd == 0) begin
      proto_errors++;
      $display("Could not open the stimulus file verif/capture_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%h %h", code, word) == 2) begin
            raw_codes.push_back(code);
            exp_words.push_back(word);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic wait_for_cs(input logic want);
    int n;
    n = 0;
    while (spi_cs !== want && n < CS_TIMEOUT) begin
      @(posedge delay_clk);
      #1;
      n++;
    end
    if (spi_cs !== want) begin
      proto_errors++;
      $display("Chip select did not go to %0d within %0d cycles", want, CS_TIMEOUT);
    end
  endtask

  // A frame is finished once chip select goes back high
  task automatic run_conversion(input int idx, input logic extra_start);
    cur_code = raw_codes[idx];
    @(posedge delay_clk);
    #1;
    start = 1'b1;
    @(posedge delay_clk);
    #1;
    start = 1'b0;
    wait_for_cs(1'b0);
    if (extra_start) begin
      repeat (3) @(posedge delay_clk);
      #1;
      start = 1'b1;
      @(posedge delay_clk);
      #1;
      start = 1'b0;
    end
    wait_for_cs(1'b1);
  endtask

  task automatic read_word(output host_word_t word, output logic got);
    @(posedge delay_clk);
    #1;
    rd = 1'b1;
    @(posedge delay_clk);
    #1;
    rd   = 1'b0;
    got  = sample_valid;
    word = sample_word;
  endtask

  task automatic expect_read(input int idx);
    host_word_t word;
    logic       got;
    read_word(word, got);
    check_flag("sample_valid", got, 1'b1);
    if (got) begin
      check_word("sample_word", word, exp_words[idx]);
    end
  endtask

  // ******************************************************************
  // Test sequence
  // ******************************************************************

  initial begin : main
    host_word_t word;
    logic       got;
    start  = 1'b0;
    rd     = 1'b0;
    arst_n = 1'b0;
    load_file();
    loaded = 1'b1;
    repeat (3) @(posedge delay_clk);
    #1;
    arst_n = 1'b1;
    check_flag("irq", irq, 1'b0);
    check_flag("overflow", overflow, 1'b0);
    check_flag("sample_valid", sample_valid, 1'b0);
    if (raw_codes.size() < OVF_CONV) begin
      proto_errors++;
      $display("Stimulus file holds %0d samples, %0d needed", raw_codes.size(), OVF_CONV);
    end else begin
      // Nothing to read yet
      read_word(word, got);
      check_flag("sample_valid", got, 1'b0);
      // Several conversions before any read, one of them with a stray start
      for (int i = 0; i < FIRST_CONV; i++) begin
        idle_gap(3);
        run_conversion(i, i == 2);
        check_flag("irq", irq, (i + 1) >= IRQ_LEVEL);
      end
      for (int i = 0; i < FIRST_CONV; i++) begin
        idle_gap(2);
        expect_read(i);
        check_flag("irq", irq, (FIRST_CONV - 1 - i) >= IRQ_LEVEL);
      end
      // Stray start added no sample
      read_word(word, got);
      check_flag("sample_valid", got, 1'b0);
      check_flag("overflow", overflow, 1'b0);
      // Fill past the depth, the last two are dropped
      for (int i = 0; i < OVF_CONV; i++) begin
        idle_gap(3);
        run_conversion(i, 1'b0);
      end
      check_flag("overflow", overflow, 1'b1);
      check_flag("irq", irq, 1'b1);
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        expect_read(i);
      end
      read_word(word, got);
      check_flag("sample_valid", got, 1'b0);
      check_flag("overflow", overflow, 1'b1);
      check_flag("irq", irq, 1'b0);
    end
    $display("Checks done with %0d value errors and %0d protocol errors",
             value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Budget grows with the number of samples in the file
  initial begin : watchdog
    wait (loaded);
    repeat (raw_codes.size() * 400 + 2000) @(posedge delay_clk);
    $display("Simulation ran out of time before the tests finished");
    $display("test failed");
    $finish;
  end

endmodule

//--- verif/adc_capture_assertions.sv
`timescale 1ns/1ns

module adc_capture_assertions
  import capture_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
) (
  input logic        delay_clk,
  input logic        arst_n,
  input logic        cnv,
  input logic        spi_cs,
  input logic        spi_sclk,
  input fifo_level_t level,
  input logic        overflow
);

  // ******************************************************************
  // Converter side protocol
  // ******************************************************************

  // A new conversion must never start inside an open frame
  cnv_outside_frame: assert property (
    @(posedge delay_clk) disable iff (!arst_n) !(cnv && !spi_cs)
  ) else $error("convert pulse high while chip select is low");

  // Serial clock is parked low between frames
  sclk_parked: assert property (
    @(posedge delay_clk) disable iff (!arst_n) spi_cs |-> !spi_sclk
  ) else $error("serial clock high while chip select is high");

  // ******************************************************************
  // FIFO side
  // ******************************************************************

  level_bounded: assert property (
    @(posedge delay_clk) disable iff (!arst_n) level <= fifo_level_t'(FIFO_DEPTH)
  ) else $error("FIFO level above its depth");

  // Overflow is sticky, only reset clears it
  overflow_sticky: assert property (
    @(posedge delay_clk) disable iff (!arst_n) !$fell(overflow)
  ) else $error("overflow flag cleared without reset");

endmodule

// Sequencer instance sees no FIFO, so those inputs are tied quiet
bind conv_sequencer adc_capture_assertions u_seq_checks (
  .delay_clk (delay_clk),
  .arst_n    (arst_n),
  .cnv       (cnv),
  .spi_cs    (spi_cs),
  .spi_sclk  (spi_sclk),
  .level     ('0),
  .overflow  (1'b0)
);

// FIFO instance sees no converter pins, so those are tied to an idle frame
bind sample_fifo adc_capture_assertions #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo_checks (
  .delay_clk (delay_clk),
  .arst_n    (arst_n),
  .cnv       (1'b0),
  .spi_cs    (1'b1),
  .spi_sclk  (1'b0),
  .level     (level),
  .overflow  (overflow)
);

//--- verilog/adc_capture_top.sv
`timescale 1ns/1ns

module adc_capture_top
  import adc_cfg_pkg::*;
  import capture_pkg::*;
#(
  parameter int SCLK_DIV   = 2,
  parameter int CNV_CYCLES = 4,
  parameter int FIFO_DEPTH = 16,
  parameter int IRQ_LEVEL  = 4
) (
  input  logic               delay_clk,
  input  logic               arst_n,
  input  logic               start,
  input  logic               busy,
  input  logic               echo_sclk,
  input  logic [NUM_SDI-1:0] sdi,
  input  logic               rd,
  output logic               cnv,
  output logic               spi_cs,
  output logic               spi_sclk,
  output host_word_t         sample_word,
  output logic               sample_valid,
  output logic               irq,
  output logic               overflow
);

  // Capture to FIFO write side
  raw_sample_t raw_sample;
  logic        raw_valid;

  // FIFO read side to the reader
  raw_sample_t head;
  logic        empty;
  fifo_level_t level;
  logic        pop;

  // ********************************************************************
  // Converter control, capture, buffer and host side
  // ********************************************************************

  conv_sequencer #(
    .SCLK_DIV   (SCLK_DIV),
    .CNV_CYCLES (CNV_CYCLES)
  ) u_conv_sequencer (
    .delay_clk (delay_clk),
    .arst_n    (arst_n),
    .start     (start),
    .busy      (busy),
    .cnv       (cnv),
    .spi_cs    (spi_cs),
    .spi_sclk  (spi_sclk)
  );

  // Chip select also tells the capture block where a frame begins
  echo_capture u_echo_capture (
    .delay_clk  (delay_clk),
    .arst_n     (arst_n),
    .spi_cs     (spi_cs),
    .echo_sclk  (echo_sclk),
    .sdi        (sdi),
    .raw_sample (raw_sample),
    .raw_valid  (raw_valid)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_sample_fifo (
    .delay_clk (delay_clk),
    .arst_n    (arst_n),
    .push      (raw_valid),
    .push_data (raw_sample),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .level     (level),
    .overflow  (overflow)
  );

  sample_reader #(
    .IRQ_LEVEL (IRQ_LEVEL)
  ) u_sample_reader (
    .delay_clk    (delay_clk),
    .arst_n       (arst_n),
    .rd           (rd),
    .head         (head),
    .empty        (empty),
    .level        (level),
    .pop          (pop),
    .sample_word  (sample_word),
    .sample_valid (sample_valid),
    .irq          (irq)
  );

endmodule

//--- verilog/sample_reader.sv
`timescale 1ns/1ns

module sample_reader
  import capture_pkg::*;
#(
  parameter int IRQ_LEVEL = 4
) (
  input  logic        delay_clk,
  input  logic        arst_n,
  input  logic        rd,
  input  raw_sample_t head,
  input  logic        empty,
  input  fifo_level_t level,
  output logic        pop,
  output host_word_t  sample_word,
  output logic        sample_valid,
  output logic        irq
);

  // Number of copies of the sign bit above the raw sample
  localparam int EXT_W = $bits(host_word_t) - $bits(raw_sample_t);

  // A host read only reaches the FIFO when there is something to take
  assign pop = rd & ~empty;

  // ********************************************************************
  // Host word register
  // ********************************************************************

  // The head word is taken in the same cycle as the pop
  always_ff @(posedge delay_clk) begin
    if (pop) begin
      sample_word <= {{EXT_W{head[$bits(raw_sample_t)-1]}}, head};
    end
  end

  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      sample_valid <= 1'b0;
    end else begin
      // One strobe per word actually popped
      sample_valid <= pop;
    end
  end

  // Interrupt follows the fill level directly
  // It drops as soon as reads bring the level under the threshold
  assign irq = (level >= fifo_level_t'(IRQ_LEVEL));

endmodule

//--- verilog/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo
  import capture_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
) (
  input  logic        delay_clk,
  input  logic        arst_n,
  input  logic        push,
  input  raw_sample_t push_data,
  input  logic        pop,
  output raw_sample_t head,
  output logic        empty,
  output fifo_level_t level,
  output logic        overflow
);

  // Depth is a power of two, so the pointers wrap on their own
  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  raw_sample_t       mem [FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic              full;
  logic              push_ok;
  logic              pop_ok;

  assign full    = (level == fifo_level_t'(FIFO_DEPTH));
  assign empty   = (level == '0);
  // Pushes into a full buffer are lost, pops from an empty one do nothing
  assign push_ok = push & ~full;
  assign pop_ok  = pop & ~empty;

  always_ff @(posedge delay_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // The oldest word is always visible at the head
  assign head = mem[rd_ptr];

  // ********************************************************************
  // Pointers, level and overflow
  // ********************************************************************

  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_ok && !pop_ok) begin
        level <= level + 1'b1;
      end else if (pop_ok && !push_ok) begin
        level <= level - 1'b1;
      end
      // Sticky until the next reset
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/echo_capture.sv
`timescale 1ns/1ns

module echo_capture
  import adc_cfg_pkg::*;
  import capture_pkg::*;
(
  input  logic               delay_clk,
  input  logic               arst_n,
  input  logic               spi_cs,
  input  logic               echo_sclk,
  input  logic [NUM_SDI-1:0] sdi,
  output raw_sample_t        raw_sample,
  output logic               raw_valid
);

  localparam int CNT_W = $clog2(BITS_PER_LANE + 1);

  // ********************************************************************
  // Input synchronizers
  // ********************************************************************

  // Clock and lanes go through identical stages so they stay aligned
  logic echo_meta;
  logic echo_sync;
  logic echo_prev;
  logic [NUM_SDI-1:0] sdi_meta;
  logic [NUM_SDI-1:0] sdi_sync;
  logic echo_rise;

  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      echo_meta <= 1'b0;
      echo_sync <= 1'b0;
      echo_prev <= 1'b0;
      sdi_meta  <= '0;
      sdi_sync  <= '0;
    end else begin
      echo_meta <= echo_sclk;
      echo_sync <= echo_meta;
      echo_prev <= echo_sync;
      sdi_meta  <= sdi;
      sdi_sync  <= sdi_meta;
    end
  end

  // A rising edge of the returned clock, as seen in the delay_clk domain
  assign echo_rise = echo_sync & ~echo_prev;

  // ********************************************************************
  // Lane shift registers and bit counter
  // ********************************************************************

  logic [NUM_SDI-1:0][BITS_PER_LANE-1:0] lane_sr;
  logic [CNT_W-1:0]                      bit_cnt;

  // Each lane shifts in its bit highest first on every echoed rising edge
  always_ff @(posedge delay_clk) begin
    if (echo_rise && !spi_cs) begin
      for (int k = 0; k < NUM_SDI; k++) begin
        lane_sr[k] <= {lane_sr[k][BITS_PER_LANE-2:0], sdi_sync[k]};
      end
    end
  end

  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt   <= '0;
      raw_valid <= 1'b0;
    end else begin
      raw_valid <= 1'b0;
      if (spi_cs) begin
        // Between frames the count starts over
        bit_cnt <= '0;
      end else if (echo_rise) begin
        if (bit_cnt == CNT_W'(BITS_PER_LANE - 1)) begin
          bit_cnt   <= '0;
          raw_valid <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // Lane k lands on bits k*BITS_PER_LANE upward, so the packed lanes
  // already form the sample word
  assign raw_sample = lane_sr;

endmodule

//--- verilog/conv_sequencer.sv
`timescale 1ns/1ns

module conv_sequencer
  import adc_cfg_pkg::*;
#(
  parameter int SCLK_DIV   = 2,
  parameter int CNV_CYCLES = 4
) (
  input  logic delay_clk,
  input  logic arst_n,
  input  logic start,
  input  logic busy,
  output logic cnv,
  output logic spi_cs,
  output logic spi_sclk
);

  // Cycles that chip select stays low after the last serial clock edge
  localparam int CS_DRAIN  = 32;
  // Index of the last half period in one frame
  localparam int HALF_LAST = 2 * BITS_PER_LANE - 1;

  // The shared counter must reach the longest of the three intervals
  localparam int CNT_A   = (CNV_CYCLES > SCLK_DIV) ? CNV_CYCLES : SCLK_DIV;
  localparam int CNT_MAX = (CS_DRAIN > CNT_A) ? CS_DRAIN : CNT_A;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);
  localparam int HALF_W  = $clog2(2 * BITS_PER_LANE + 1);

  seq_state_t        state;
  logic [CNT_W-1:0]  div_cnt;
  logic [HALF_W-1:0] half_cnt;

  // Busy comes straight from the converter and is not related to delay_clk
  logic busy_meta;
  logic busy_sync;
  logic busy_prev;
  logic busy_fall;

  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_meta <= 1'b0;
      busy_sync <= 1'b0;
      busy_prev <= 1'b0;
    end else begin
      busy_meta <= busy;
      busy_sync <= busy_meta;
      busy_prev <= busy_sync;
    end
  end

  // The conversion is over once the synchronized busy goes back low
  assign busy_fall = busy_prev & ~busy_sync;

  // ********************************************************************
  // Frame state machine
  // ********************************************************************

  always_ff @(posedge delay_clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= seq_idle;
      div_cnt  <= '0;
      half_cnt <= '0;
      cnv      <= 1'b0;
      spi_cs   <= 1'b1;
      spi_sclk <= 1'b0;
    end else begin
      case (state)
        seq_idle: begin
          // Start requests are only taken here, all others are ignored
          if (start) begin
            state   <= seq_convert;
            cnv     <= 1'b1;
            div_cnt <= '0;
          end
        end
        seq_convert: begin
          if (div_cnt == CNT_W'(CNV_CYCLES - 1)) begin
            state   <= seq_wait_busy;
            cnv     <= 1'b0;
            div_cnt <= '0;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        seq_wait_busy: begin
          // Open the frame with the serial clock parked low
          if (busy_fall) begin
            state    <= seq_shift;
            spi_cs   <= 1'b0;
            spi_sclk <= 1'b0;
            div_cnt  <= '0;
            half_cnt <= '0;
          end
        end
        seq_shift: begin
          if (div_cnt == CNT_W'(SCLK_DIV - 1)) begin
            div_cnt  <= '0;
            spi_sclk <= ~spi_sclk;
            half_cnt <= half_cnt + 1'b1;
            // The last toggle returns the clock low and ends the frame
            if (half_cnt == HALF_W'(HALF_LAST)) begin
              state <= seq_cs_hold;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        seq_cs_hold: begin
          // The board returns the clock late, so keep the frame open a while
          if (div_cnt == CNT_W'(CS_DRAIN - 1)) begin
            state   <= seq_idle;
            spi_cs  <= 1'b1;
            div_cnt <= '0;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: begin
          state <= seq_idle;
        end
      endcase
    end
  end

endmodule

//--- verilog/capture_pkg.sv
// ********************************************************************
// Captured data types shared by the capture path, FIFO and reader
// ********************************************************************

package capture_pkg;

  import adc_cfg_pkg::*;

  // One raw sample as rebuilt from the lanes, two's complement
  typedef logic signed [SAMPLE_WIDTH-1:0] raw_sample_t;

  // Word width seen by the host
  localparam int HOST_WIDTH = 32;

  // One host word, the raw sample sign-extended
  typedef logic [HOST_WIDTH-1:0] host_word_t;

  // FIFO fill count
  // Five bits hold every level from empty up to a depth of 16
  typedef logic [4:0] fifo_level_t;

endpackage

//--- verilog/adc_cfg_pkg.sv
// ********************************************************************
// Converter side description of the multi-lane echo clock ADC
// ********************************************************************

package adc_cfg_pkg;

  // Number of serial data lanes driven by the converter
  localparam int NUM_SDI = 4;

  // Serial clock periods in one frame, which is also the bits per lane
  localparam int BITS_PER_LANE = 4;

  // One raw sample is the concatenation of all lanes
  localparam int SAMPLE_WIDTH = NUM_SDI * BITS_PER_LANE;

  // Conversion sequencer states
  // Idle waits for a start request, convert holds the convert pulse,
  // wait_busy waits for the converter to finish, shift runs the serial
  // clock and cs_hold keeps chip select low while the echo drains
  typedef enum logic [2:0] {
    seq_idle      = 3'd0,
    seq_convert   = 3'd1,
    seq_wait_busy = 3'd2,
    seq_shift     = 3'd3,
    seq_cs_hold   = 3'd4
  } seq_state_t;

endpackage
